//--- include/bilin_params.svh
`ifndef BILIN_PARAMS_SVH
`define BILIN_PARAMS_SVH

// ------------------------------
// Memory geometry
// ------------------------------

// Linear address width of the input and output image memories
`define BILIN_AW 19

// Output pixels handled per group, one read and one write port each
`define BILIN_LANES 4

// ------------------------------
// Fixed-point constants
// ------------------------------

// 1.0 in Q0.8, needs the ninth bit
`define BILIN_ONE_Q08 9'd256

// Half an LSB of the Q8.16 sum, for round to nearest
`define BILIN_ROUND_Q016 32'h0000_8000

`endif

//--- logic/bilin_pkg.sv
`default_nettype none

`include "bilin_params.svh"

package bilin_pkg;

  // ------------------------------
  // Scalar formats
  // ------------------------------

  // Width, height or integer coordinate
  typedef logic [15:0] dim_t;
  // 8-bit grey pixel
  typedef logic [7:0] pix_t;
  // Q0.8 fraction
  typedef logic [7:0] frac_t;
  // Q1.8 weight, reaches 1.0
  typedef logic [8:0] weight_t;
  // Q8.8 scale and inverse scale
  typedef logic [15:0] scale_t;
  // Q16.8 source position
  typedef logic [23:0] fix_t;
  // Q8.16 product or sum
  typedef logic [31:0] acc_t;
  typedef logic [`BILIN_AW-1:0] addr_t;

  // ------------------------------
  // Bundles
  // ------------------------------

  // Per-lane coordinates after edge clamping
  typedef struct packed {
    dim_t  col;
    frac_t fx;
    addr_t addr;
    logic  in_range;
  } lane_coord_t;

  // Shared source row of the group
  typedef struct packed {
    dim_t  row;
    frac_t fy;
  } row_coord_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    pix_t  data;
  } wr_port_t;

  // Neighbour select {dx, dy}: 00, 10, 01, 11
  typedef logic [1:0] nbr_sel_t;

  // Controller states, one address and one data state per neighbour
  typedef enum logic [3:0] {
    S_IDLE,
    S_INIT,
    S_ROW_START,
    S_SETUP,
    S_A00,
    S_D00,
    S_A10,
    S_D10,
    S_A01,
    S_D01,
    S_A11,
    S_D11,
    S_MUL,
    S_WRITE,
    S_ADVANCE,
    S_DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/bilin_scale_setup.sv
`default_nettype none

module bilin_scale_setup (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              i_start,
  input  wire logic              i_idle,
  input  wire bilin_pkg::dim_t   i_in_w,
  input  wire bilin_pkg::dim_t   i_in_h,
  input  wire bilin_pkg::scale_t i_scale,
  output bilin_pkg::dim_t        o_out_w,
  output bilin_pkg::dim_t        o_out_h,
  output bilin_pkg::dim_t        o_groups,
  output bilin_pkg::scale_t      o_inv_step
);

  // Size times Q8.8 scale, integer part sits in 23:8
  logic [31:0]       mul_w;
  logic [31:0]       mul_h;
  // One extra bit so out_w + 3 cannot wrap
  logic [16:0]       groups_sum;
  bilin_pkg::scale_t inv_nxt;

  assign mul_w      = i_in_w * i_scale;
  assign mul_h      = i_in_h * i_scale;
  assign groups_sum = {1'b0, mul_w[23:8]} + 17'd3;

  // floor(65536 / scale), all ones when scale is zero
  always_comb begin
    if (i_scale == 16'd0) begin
      inv_nxt = 16'hffff;
    end else begin
      inv_nxt = bilin_pkg::scale_t'(32'd65536 / {16'd0, i_scale});
    end
  end

  // Job latched on the start edge, held until the next start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_out_w    <= '0;
      o_out_h    <= '0;
      o_groups   <= '0;
      o_inv_step <= '0;
    end else if (i_start && i_idle) begin
      o_out_w    <= mul_w[23:8];
      o_out_h    <= mul_h[23:8];
      // Ceil of out_w / 4
      o_groups   <= groups_sum[17-1:2];
      o_inv_step <= inv_nxt;
    end
  end

endmodule

`default_nettype wire

//--- logic/bilin_coord_gen.sv
`default_nettype none

`include "bilin_params.svh"

module bilin_coord_gen (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              i_row_start,
  input  wire logic              i_group_setup,
  input  wire logic              i_advance,
  input  wire bilin_pkg::dim_t   i_in_w,
  input  wire bilin_pkg::dim_t   i_in_h,
  input  wire bilin_pkg::dim_t   i_out_w,
  input  wire bilin_pkg::dim_t   i_out_h,
  input  wire bilin_pkg::dim_t   i_groups,
  input  wire bilin_pkg::scale_t i_inv_step,
  output bilin_pkg::lane_coord_t o_lane [`BILIN_LANES],
  output bilin_pkg::row_coord_t  o_row,
  output logic                   o_last_group,
  output logic                   o_last_row
);

  // Walk position, Q16.8 in the source image
  bilin_pkg::fix_t sy_fix;
  bilin_pkg::fix_t sx_group;
  // Walk position in the output image
  bilin_pkg::dim_t out_row;
  bilin_pkg::dim_t group_idx;

  bilin_pkg::fix_t step_1x;
  bilin_pkg::fix_t step_4x;

  bilin_pkg::lane_coord_t lane_nxt [`BILIN_LANES];
  bilin_pkg::row_coord_t  row_nxt;

  assign step_1x = {8'd0, i_inv_step};
  assign step_4x = step_1x << 2;

  // Compared in 17 bits so the +1 never wraps
  assign o_last_group = ({1'b0, group_idx} + 17'd1) >= {1'b0, i_groups};
  assign o_last_row   = ({1'b0, out_row} + 17'd1) >= {1'b0, i_out_h};

  // ------------------------------
  // Clamped coordinates
  // ------------------------------

  // Last source row has no row below it
  always_comb begin
    row_nxt.row = sy_fix[23:8];
    row_nxt.fy  = sy_fix[7:0];
    if (sy_fix[23:8] >= i_in_h - 16'd1) begin
      row_nxt.row = i_in_h - 16'd2;
      row_nxt.fy  = 8'hff;
    end
  end

  // Lanes sit one inverse step apart
  always_comb begin
    bilin_pkg::fix_t sx;
    bilin_pkg::dim_t ox;
    logic [31:0]     lin;
    for (int i = 0; i < `BILIN_LANES; i++) begin
      sx = sx_group + step_1x * bilin_pkg::fix_t'(i);
      ox = {group_idx[13:0], 2'b00} + bilin_pkg::dim_t'(i);
      lin = out_row * i_out_w + ox;
      lane_nxt[i].col      = sx[23:8];
      lane_nxt[i].fx       = sx[7:0];
      lane_nxt[i].addr     = lin[`BILIN_AW-1:0];
      // Tail lanes of the last group fall outside the row
      lane_nxt[i].in_range = ox < i_out_w;
      if (sx[23:8] >= i_in_w - 16'd1) begin
        lane_nxt[i].col = i_in_w - 16'd2;
        lane_nxt[i].fx  = 8'hff;
      end
    end
  end

  // Held through reads, multiply and write
  always_ff @(posedge clk) begin
    if (i_group_setup) begin
      o_lane <= lane_nxt;
      o_row  <= row_nxt;
    end
  end

  // ------------------------------
  // Walk state
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sy_fix    <= '0;
      sx_group  <= '0;
      out_row   <= '0;
      group_idx <= '0;
    end else if (i_row_start) begin
      sx_group  <= '0;
      group_idx <= '0;
    end else if (i_advance) begin
      if (!o_last_group) begin
        sx_group  <= sx_group + step_4x;
        group_idx <= group_idx + 16'd1;
      end else if (!o_last_row) begin
        sy_fix  <= sy_fix + step_1x;
        out_row <= out_row + 16'd1;
      end else begin
        // End of image, rewind the rows for the next job
        sy_fix  <= '0;
        out_row <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/bilin_lane_interp.sv
`default_nettype none

`include "bilin_params.svh"

module bilin_lane_interp (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                i_capture,
  input  wire bilin_pkg::nbr_sel_t i_nbr,
  input  wire bilin_pkg::pix_t     i_rd_data,
  input  wire logic                i_multiply,
  input  wire bilin_pkg::frac_t    i_fx,
  input  wire bilin_pkg::frac_t    i_fy,
  output bilin_pkg::pix_t          o_pix
);

  // Neighbour pixels, suffix is {dx, dy}
  bilin_pkg::pix_t n00;
  bilin_pkg::pix_t n10;
  bilin_pkg::pix_t n01;
  bilin_pkg::pix_t n11;

  bilin_pkg::weight_t wx0;
  bilin_pkg::weight_t wx1;
  bilin_pkg::weight_t wy0;
  bilin_pkg::weight_t wy1;

  // Q0.16 corner weights, 1.0 needs bit 16
  logic [17:0] w00;
  logic [17:0] w10;
  logic [17:0] w01;
  logic [17:0] w11;

  bilin_pkg::acc_t p00;
  bilin_pkg::acc_t p10;
  bilin_pkg::acc_t p01;
  bilin_pkg::acc_t p11;
  bilin_pkg::acc_t sum;
  bilin_pkg::acc_t sum_rnd;

  // One neighbour per data cycle
  always_ff @(posedge clk) begin
    if (i_capture) begin
      case (i_nbr)
        2'b00:   n00 <= i_rd_data;
        2'b10:   n10 <= i_rd_data;
        2'b01:   n01 <= i_rd_data;
        default: n11 <= i_rd_data;
      endcase
    end
  end

  // Weights from the two fractions
  assign wx1 = {1'b0, i_fx};
  assign wx0 = `BILIN_ONE_Q08 - wx1;
  assign wy1 = {1'b0, i_fy};
  assign wy0 = `BILIN_ONE_Q08 - wy1;

  assign w00 = wx0 * wy0;
  assign w10 = wx1 * wy0;
  assign w01 = wx0 * wy1;
  assign w11 = wx1 * wy1;

  // Products registered to split the multiply from the adder tree
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p00 <= '0;
      p10 <= '0;
      p01 <= '0;
      p11 <= '0;
    end else if (i_multiply) begin
      p00 <= w00 * n00;
      p10 <= w10 * n10;
      p01 <= w01 * n01;
      p11 <= w11 * n11;
    end
  end

  // Q8.16 sum, rounded to the nearest integer
  assign sum     = p00 + p10 + p01 + p11;
  assign sum_rnd = sum + `BILIN_ROUND_Q016;
  assign o_pix   = sum_rnd[23:16];

endmodule

`default_nettype wire

//--- logic/bilin_ctrl.sv
`default_nettype none

`include "bilin_params.svh"

module bilin_ctrl (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   i_start,
  input  wire bilin_pkg::dim_t        i_in_w,
  input  wire bilin_pkg::dim_t        i_out_w,
  input  wire bilin_pkg::lane_coord_t i_lane [`BILIN_LANES],
  input  wire bilin_pkg::row_coord_t  i_row,
  input  wire logic                   i_last_group,
  input  wire logic                   i_last_row,
  input  wire bilin_pkg::pix_t        i_pix [`BILIN_LANES],
  output logic                        o_idle,
  output logic                        o_busy,
  output logic                        o_done,
  output logic                        o_row_start,
  output logic                        o_group_setup,
  output logic                        o_advance,
  output logic                        o_capture,
  output logic                        o_multiply,
  output bilin_pkg::nbr_sel_t         o_nbr,
  output bilin_pkg::addr_t            o_rd_addr [`BILIN_LANES],
  output bilin_pkg::wr_port_t         o_wr [`BILIN_LANES]
);

  bilin_pkg::ctrl_state_t state;
  bilin_pkg::ctrl_state_t state_nxt;

  logic addr_cycle;
  logic wr_cycle;

  // Row-major linear address
  function automatic bilin_pkg::addr_t lin_addr(
    input bilin_pkg::dim_t x,
    input bilin_pkg::dim_t y,
    input bilin_pkg::dim_t w
  );
    logic [31:0] tmp;
    tmp = y * w + x;
    return tmp[`BILIN_AW-1:0];
  endfunction

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      bilin_pkg::S_IDLE: begin
        if (i_start) begin
          state_nxt = bilin_pkg::S_INIT;
        end
      end
      // Job size is valid here, an empty row means nothing to write
      bilin_pkg::S_INIT: begin
        if (i_out_w == 16'd0) begin
          state_nxt = bilin_pkg::S_DONE;
        end else begin
          state_nxt = bilin_pkg::S_ROW_START;
        end
      end
      bilin_pkg::S_ROW_START: state_nxt = bilin_pkg::S_SETUP;
      bilin_pkg::S_SETUP:     state_nxt = bilin_pkg::S_A00;
      bilin_pkg::S_A00:       state_nxt = bilin_pkg::S_D00;
      bilin_pkg::S_D00:       state_nxt = bilin_pkg::S_A10;
      bilin_pkg::S_A10:       state_nxt = bilin_pkg::S_D10;
      bilin_pkg::S_D10:       state_nxt = bilin_pkg::S_A01;
      bilin_pkg::S_A01:       state_nxt = bilin_pkg::S_D01;
      bilin_pkg::S_D01:       state_nxt = bilin_pkg::S_A11;
      bilin_pkg::S_A11:       state_nxt = bilin_pkg::S_D11;
      bilin_pkg::S_D11:       state_nxt = bilin_pkg::S_MUL;
      bilin_pkg::S_MUL:       state_nxt = bilin_pkg::S_WRITE;
      bilin_pkg::S_WRITE:     state_nxt = bilin_pkg::S_ADVANCE;
      // Write strobes are out during this cycle
      bilin_pkg::S_ADVANCE: begin
        if (!i_last_group) begin
          state_nxt = bilin_pkg::S_SETUP;
        end else if (!i_last_row) begin
          state_nxt = bilin_pkg::S_ROW_START;
        end else begin
          state_nxt = bilin_pkg::S_DONE;
        end
      end
      default: state_nxt = bilin_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= bilin_pkg::S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ------------------------------
  // Decoded strobes
  // ------------------------------
  assign o_idle        = state == bilin_pkg::S_IDLE;
  assign o_done        = state == bilin_pkg::S_DONE;
  assign o_busy        = !o_idle && !o_done;
  assign o_row_start   = state == bilin_pkg::S_ROW_START;
  assign o_group_setup = state == bilin_pkg::S_SETUP;
  assign o_multiply    = state == bilin_pkg::S_MUL;
  assign o_advance     = state == bilin_pkg::S_ADVANCE;
  assign wr_cycle      = state == bilin_pkg::S_WRITE;

  assign addr_cycle = state inside {bilin_pkg::S_A00, bilin_pkg::S_A10,
                                    bilin_pkg::S_A01, bilin_pkg::S_A11};
  assign o_capture  = state inside {bilin_pkg::S_D00, bilin_pkg::S_D10,
                                    bilin_pkg::S_D01, bilin_pkg::S_D11};

  // Same select in the address and the data cycle of a neighbour
  always_comb begin
    case (state)
      bilin_pkg::S_A10, bilin_pkg::S_D10: o_nbr = 2'b10;
      bilin_pkg::S_A01, bilin_pkg::S_D01: o_nbr = 2'b01;
      bilin_pkg::S_A11, bilin_pkg::S_D11: o_nbr = 2'b11;
      default:                            o_nbr = 2'b00;
    endcase
  end

  // Read address, data comes back in the following cycle
  always_ff @(posedge clk) begin
    if (addr_cycle) begin
      for (int i = 0; i < `BILIN_LANES; i++) begin
        o_rd_addr[i] <= lin_addr(i_lane[i].col + {15'd0, o_nbr[1]},
                                 i_row.row + {15'd0, o_nbr[0]}, i_in_w);
      end
    end
  end

  // ------------------------------
  // Write ports
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `BILIN_LANES; i++) begin
        o_wr[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `BILIN_LANES; i++) begin
        // Single-cycle strobe, only for columns inside the output row
        o_wr[i].en <= wr_cycle && i_lane[i].in_range;
        if (wr_cycle) begin
          o_wr[i].addr <= i_lane[i].addr;
          o_wr[i].data <= i_pix[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/bilin_simd4_top.sv
`default_nettype none

`include "bilin_params.svh"

module bilin_simd4_top (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              i_start,
  input  wire bilin_pkg::dim_t   i_in_w,
  input  wire bilin_pkg::dim_t   i_in_h,
  input  wire bilin_pkg::scale_t i_scale,
  input  wire bilin_pkg::pix_t   i_rd_data [`BILIN_LANES],
  output logic                   o_busy,
  output logic                   o_done,
  output bilin_pkg::dim_t        o_out_w,
  output bilin_pkg::dim_t        o_out_h,
  output bilin_pkg::addr_t       o_rd_addr [`BILIN_LANES],
  output bilin_pkg::wr_port_t    o_wr [`BILIN_LANES]
);

  // Job values from setup
  bilin_pkg::dim_t   groups;
  bilin_pkg::scale_t inv_step;

  // Controller strobes
  logic                idle;
  logic                row_start;
  logic                group_setup;
  logic                advance;
  logic                capture;
  logic                multiply;
  bilin_pkg::nbr_sel_t nbr;

  // Coordinates for the current group
  bilin_pkg::lane_coord_t lane [`BILIN_LANES];
  bilin_pkg::row_coord_t  row;
  logic                   last_group;
  logic                   last_row;

  bilin_pkg::pix_t pix [`BILIN_LANES];

  bilin_scale_setup scale_setup_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_start    (i_start),
    .i_idle     (idle),
    .i_in_w     (i_in_w),
    .i_in_h     (i_in_h),
    .i_scale    (i_scale),
    .o_out_w    (o_out_w),
    .o_out_h    (o_out_h),
    .o_groups   (groups),
    .o_inv_step (inv_step)
  );

  bilin_coord_gen coord_gen_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_row_start   (row_start),
    .i_group_setup (group_setup),
    .i_advance     (advance),
    .i_in_w        (i_in_w),
    .i_in_h        (i_in_h),
    .i_out_w       (o_out_w),
    .i_out_h       (o_out_h),
    .i_groups      (groups),
    .i_inv_step    (inv_step),
    .o_lane        (lane),
    .o_row         (row),
    .o_last_group  (last_group),
    .o_last_row    (last_row)
  );

  bilin_ctrl ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start),
    .i_in_w        (i_in_w),
    .i_out_w       (o_out_w),
    .i_lane        (lane),
    .i_row         (row),
    .i_last_group  (last_group),
    .i_last_row    (last_row),
    .i_pix         (pix),
    .o_idle        (idle),
    .o_busy        (o_busy),
    .o_done        (o_done),
    .o_row_start   (row_start),
    .o_group_setup (group_setup),
    .o_advance     (advance),
    .o_capture     (capture),
    .o_multiply    (multiply),
    .o_nbr         (nbr),
    .o_rd_addr     (o_rd_addr),
    .o_wr          (o_wr)
  );

  // ------------------------------
  // Lane datapaths
  // ------------------------------

  // Each lane owns one read port, all share the row fraction
  for (genvar g = 0; g < `BILIN_LANES; g++) begin : g_lane
    bilin_lane_interp lane_interp_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .i_capture  (capture),
      .i_nbr      (nbr),
      .i_rd_data  (i_rd_data[g]),
      .i_multiply (multiply),
      .i_fx       (lane[g].fx),
      .i_fy       (row.fy),
      .o_pix      (pix[g])
    );
  end

endmodule

`default_nettype wire

//--- test/bilin_checker.sv
`default_nettype none

`include "bilin_params.svh"

module bilin_checker #(
  parameter int IMG_WORDS = 256
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                i_start,
  input  wire logic                i_busy,
  input  wire logic                i_done,
  input  wire bilin_pkg::dim_t     i_out_w,
  input  wire bilin_pkg::dim_t     i_out_h,
  input  wire bilin_pkg::dim_t     i_exp_w,
  input  wire bilin_pkg::dim_t     i_exp_h,
  input  wire bilin_pkg::pix_t     i_exp_pix [IMG_WORDS],
  input  wire bilin_pkg::wr_port_t i_wr [`BILIN_LANES],
  output int                       o_errors,
  output int                       o_writes,
  output int                       o_jobs
);
  timeunit 1ns;
  timeprecision 1ps;

  // Addresses hit in the running job
  logic written [IMG_WORDS];
  logic active;
  logic prev_done;
  int   job_writes;

  task automatic report_value(input string name, input int expected, input int actual);
    $display("[ERROR] %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    o_errors = o_errors + 1;
  endtask

  task automatic report_fault(input string what);
    $display("Failure at %0t: %s", $time, what);
    o_errors = o_errors + 1;
  endtask

  // End of job, size and coverage of the output image
  task automatic close_job();
    int n_out;
    int missing;
    n_out   = int'(i_exp_w) * int'(i_exp_h);
    missing = 0;
    if (i_out_w != i_exp_w) begin
      report_value("o_out_w", int'(i_exp_w), int'(i_out_w));
    end
    if (i_out_h != i_exp_h) begin
      report_value("o_out_h", int'(i_exp_h), int'(i_out_h));
    end
    if (i_busy) begin
      report_value("o_busy", 0, 1);
    end
    for (int a = 0; a < n_out && a < IMG_WORDS; a++) begin
      if (!written[a]) begin
        missing = missing + 1;
      end
    end
    if (missing != 0) begin
      report_fault($sformatf("%0d output pixels were never written", missing));
    end
    if (job_writes != n_out) begin
      report_value("write count", n_out, job_writes);
    end
  endtask

  // ------------------------------
  // Sampled on every rising edge
  // ------------------------------
  always @(posedge clk) begin
    int a;
    if (!rst_n) begin
      o_errors   = 0;
      o_writes   = 0;
      o_jobs     = 0;
      active     = 1'b0;
      prev_done  = 1'b0;
      job_writes = 0;
    end else begin
      if (i_done && prev_done) begin
        report_fault("done stayed high for more than one cycle");
      end
      if (!active) begin
        // Idle between jobs and after reset
        if (i_busy) begin
          report_value("o_busy", 0, 1);
        end
        if (i_done) begin
          report_fault("done pulse without a running job");
        end
        for (int i = 0; i < `BILIN_LANES; i++) begin
          if (i_wr[i].en) begin
            report_value($sformatf("o_wr[%0d].en", i), 0, 1);
          end
        end
        if (i_start) begin
          active     = 1'b1;
          job_writes = 0;
          for (int k = 0; k < IMG_WORDS; k++) begin
            written[k] = 1'b0;
          end
        end
      end else begin
        // Write ports of the running job
        for (int i = 0; i < `BILIN_LANES; i++) begin
          if (i_wr[i].en) begin
            a = int'(i_wr[i].addr);
            job_writes = job_writes + 1;
            o_writes   = o_writes + 1;
            if (a >= int'(i_exp_w) * int'(i_exp_h) || a >= IMG_WORDS) begin
              report_fault($sformatf("lane %0d wrote address %0d outside the image", i, a));
            end else if (written[a]) begin
              report_fault($sformatf("lane %0d wrote address %0d a second time", i, a));
            end else begin
              written[a] = 1'b1;
              if (i_wr[i].data !== i_exp_pix[a]) begin
                report_value($sformatf("o_wr[%0d].data at address %0d", i, a),
                             int'(i_exp_pix[a]), int'(i_wr[i].data));
              end
            end
          end
        end
        if (i_done) begin
          close_job();
          o_jobs = o_jobs + 1;
          active = 1'b0;
        end else if (!i_busy) begin
          report_value("o_busy", 1, 0);
        end
      end
      prev_done = i_done;
    end
  end

endmodule

`default_nettype wire

//--- test/tb_bilin_simd4.sv
`default_nettype none

`include "bilin_params.svh"

module tb_bilin_simd4;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int STIM_WORDS = 512;
  localparam int IMG_WORDS  = 256;

  // DUT inputs
  logic                clk;
  logic                rst_n;
  logic                start;
  bilin_pkg::dim_t     in_w;
  bilin_pkg::dim_t     in_h;
  bilin_pkg::scale_t   scale;
  bilin_pkg::pix_t     rd_data [`BILIN_LANES];

  // DUT outputs
  logic                busy;
  logic                done;
  bilin_pkg::dim_t     out_w;
  bilin_pkg::dim_t     out_h;
  bilin_pkg::addr_t    rd_addr [`BILIN_LANES];
  bilin_pkg::wr_port_t wr [`BILIN_LANES];

  // Case data, source image and expected image of the running case
  logic [15:0]         stim [STIM_WORDS];
  bilin_pkg::pix_t     img [IMG_WORDS];
  bilin_pkg::pix_t     exp_pix [IMG_WORDS];
  bilin_pkg::dim_t     exp_w;
  bilin_pkg::dim_t     exp_h;

  int                  errors;
  int                  writes;
  int                  jobs;
  int                  n_case;
  int                  limit_cycles;
  logic                limit_ready;
  int                  seed;

  // 10 ns clock
  initial clk = 1'b0;
  always #5 clk = ~clk;

  bilin_simd4_top bilin_simd4_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_start   (start),
    .i_in_w    (in_w),
    .i_in_h    (in_h),
    .i_scale   (scale),
    .i_rd_data (rd_data),
    .o_busy    (busy),
    .o_done    (done),
    .o_out_w   (out_w),
    .o_out_h   (out_h),
    .o_rd_addr (rd_addr),
    .o_wr      (wr)
  );

  bilin_checker #(.IMG_WORDS(IMG_WORDS)) bilin_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_start   (start),
    .i_busy    (busy),
    .i_done    (done),
    .i_out_w   (out_w),
    .i_out_h   (out_h),
    .i_exp_w   (exp_w),
    .i_exp_h   (exp_h),
    .i_exp_pix (exp_pix),
    .i_wr      (wr),
    .o_errors  (errors),
    .o_writes  (writes),
    .o_jobs    (jobs)
  );

  // ------------------------------
  // Input image memory
  // ------------------------------

  // Address registered by the DUT, data back in the following cycle
  always @(posedge clk) begin
    #1;
    for (int i = 0; i < `BILIN_LANES; i++) begin
      rd_data[i] = img[rd_addr[i][7:0]];
    end
  end

  // Words one case takes in the data file
  function automatic int case_words(input int base);
    int n_in;
    int n_out;
    n_in  = int'(stim[base]) * int'(stim[base + 1]);
    n_out = int'(stim[base + 3]) * int'(stim[base + 4]);
    return 5 + n_in + n_out;
  endfunction

  // Load one case, pulse start, wait for done
  task automatic run_case(input int base);
    int n_in;
    int n_out;
    n_in  = int'(stim[base]) * int'(stim[base + 1]);
    n_out = int'(stim[base + 3]) * int'(stim[base + 4]);
    for (int k = 0; k < n_in; k++) begin
      img[k] = stim[base + 5 + k][7:0];
    end
    for (int k = 0; k < n_out; k++) begin
      exp_pix[k] = stim[base + 5 + n_in + k][7:0];
    end
    exp_w = stim[base + 3];
    exp_h = stim[base + 4];
    in_w  = stim[base];
    in_h  = stim[base + 1];
    scale = stim[base + 2];
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    while (!done) begin
      @(posedge clk);
      #1;
    end
    // Back to idle before the next start
    @(posedge clk);
    #1;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int pos;
    int total_pix;
    seed        = 32'h305d;
    rst_n       = 1'b0;
    start       = 1'b0;
    in_w        = '0;
    in_h        = '0;
    scale       = '0;
    exp_w       = '0;
    exp_h       = '0;
    n_case      = 0;
    limit_ready = 1'b0;
    for (int i = 0; i < `BILIN_LANES; i++) begin
      rd_data[i] = '0;
    end
    for (int k = 0; k < IMG_WORDS; k++) begin
      img[k]     = '0;
      exp_pix[k] = '0;
    end
    $readmemh("test/bilin_input.txt", stim);

    // Time budget from the output size of all cases
    pos       = 0;
    total_pix = 0;
    while (stim[pos] != 16'd0) begin
      total_pix = total_pix + int'(stim[pos + 3]) * int'(stim[pos + 4]);
      pos = pos + case_words(pos);
    end
    limit_cycles = 20 * total_pix + 1000;
    limit_ready  = 1'b1;

    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    pos = 0;
    while (stim[pos] != 16'd0) begin
      run_case(pos);
      n_case = n_case + 1;
      pos = pos + case_words(pos);
    end
    @(posedge clk);
    #1;

    $display("Summary: %0d cases, %0d jobs, %0d writes, %0d errors",
             n_case, jobs, writes, errors);
    if (errors == 0 && jobs == n_case && n_case > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/bilin_input.txt
// Per case: in_w in_h scale out_w out_h, input pixels row by row, expected pixels row by row
// A zero width ends the list, all values in hex
0004 0004 0200 0008 0008
0a 1e 32 46 32 46 5a 6e 5a 6e 82 96 82 96 aa be
0a 14 1e 28 32 3c 46 46 1e 28 32 3c 46 50 5a 5a 32 3c 46 50 5a 64 6e 6e 46 50 5a 64 6e 78 82 82
5a 64 6e 78 82 8c 96 96 6e 78 82 8c 96 a0 aa aa 82 8c 96 a0 aa b4 be be 82 8c 96 a0 aa b4 be be
0006 0005 0180 0009 0007
05 25 45 65 85 a5 15 35 55 75 95 b5 25 45 65 85 a5 c5 35 55 75 95 b5 d5 45 65 85 a5 c5 e5
05 1a 30 45 5a 6f 85 9a a5 10 25 3a 4f 65 7a 8f a4 b0 1a 30 45 5a 6f 85 9a af ba
25 3a 4f 65 7a 8f a4 ba c5 30 45 5a 6f 85 9a af c4 cf 3a 4f 65 7a 8f a4 ba cf da
45 5a 6f 85 9a af c4 da e5
0008 0008 0080 0004 0004
03 0b 13 1b 23 2b 33 3b 1b 23 2b 33 3b 43 4b 53 33 3b 43 4b 53 5b 63 6b 4b 53 5b 63 6b 73 7b 83
63 6b 73 7b 83 8b 93 9b 7b 83 8b 93 9b a3 ab b3 93 9b a3 ab b3 bb c3 cb ab b3 bb c3 cb d3 db e3
03 13 23 33 33 43 53 63 63 73 83 93 93 a3 b3 c3
0000

//--- filelist.f
+incdir+include
logic/bilin_pkg.sv
logic/bilin_scale_setup.sv
logic/bilin_coord_gen.sv
logic/bilin_lane_interp.sv
logic/bilin_ctrl.sv
logic/bilin_simd4_top.sv
test/bilin_checker.sv
test/tb_bilin_simd4.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_bilin_simd4
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard include/*.svh logic/*.sv test/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
